//--- src/cnn_pkg.sv
package cnn_pkg;

    // basic widths
    typedef logic [7:0]  byte_t;      // feature, weight, bias or apb data byte
    typedef logic [9:0]  mem_addr_t;  // byte index into the layer memory
    typedef logic [23:0] acc_t;       // class score, room for 256 products plus bias
    typedef logic [3:0]  class_t;     // class index
    typedef logic [11:0] apb_addr_t;  // apb byte address

    // default layer size, the top level hands these down
    localparam int DEF_N_IN    = 49;
    localparam int DEF_N_CLASS = 10;

    // register map above the memory window
    localparam apb_addr_t CTRL_ADDR   = 12'h400;  // bit 0 starts a run
    localparam apb_addr_t STATUS_ADDR = 12'h404;  // busy, valid, answer

    // one write into the layer memory
    typedef struct packed {
        logic      en;
        mem_addr_t addr;
        byte_t     data;
    } mem_wr_t;

    // memory layout, in bytes:
    //   features  at 0 .. N_IN-1
    //   weights   at N_IN + c*N_IN + i
    //   biases    at N_IN*(1+N_CLASS) + c
    // each module works out its own bases from N_IN and N_CLASS

    // dense classifier sequencing
    //   IDLE     waiting for start
    //   MAC      one feature x weight per cycle
    //   BIAS     last product lands, bias address goes out
    //   COMPARE  score = acc + bias, running max update
    //   DONE     answer held with valid
    typedef enum logic [2:0] {
        IDLE,
        MAC,
        BIAS,
        COMPARE,
        DONE
    } cls_state_t;

endpackage

//--- src/apb_frontend.sv
module apb_frontend #(
    parameter int N_IN    = 49,
    parameter int N_CLASS = 10
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  cnn_pkg::apb_addr_t paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    input  logic               busy,
    input  logic               valid,
    input  cnn_pkg::class_t    answer,
    output cnn_pkg::mem_wr_t   mem_wr,
    output logic               start
);
    import cnn_pkg::*;

    // features, weights and biases
    localparam int        MEM_SIZE  = N_IN * (1 + N_CLASS) + N_CLASS;
    localparam apb_addr_t MEM_LIMIT = apb_addr_t'(MEM_SIZE);

    logic access;
    logic mem_wr_sel;
    logic ctrl_wr;
    logic status_rd;
    logic mapped;
    logic start_req;
    logic err;

    assign access = psel && penable;  // apb access phase

    // address decode
    assign mem_wr_sel = pwrite && (paddr < CTRL_ADDR);
    assign ctrl_wr    = pwrite && (paddr == CTRL_ADDR);
    assign status_rd  = !pwrite && (paddr == STATUS_ADDR);
    assign mapped     = mem_wr_sel || ctrl_wr || status_rd;
    assign start_req  = ctrl_wr && pwdata[0];

    // error rules, an errored transfer has no side effect
    always_comb begin
        err = 1'b0;
        if (!mapped) begin
            err = 1'b1;  // memory reads land here too
        end else if (mem_wr_sel && (paddr >= MEM_LIMIT || busy)) begin
            err = 1'b1;
        end else if (start_req && busy) begin
            err = 1'b1;  // no restart mid run
        end
    end

    // zero wait state slave
    assign pready  = 1'b1;
    assign pslverr = access && err;

    // memory write lands on the edge that closes the access phase
    always_comb begin
        mem_wr.en   = access && mem_wr_sel && !err;
        mem_wr.addr = paddr[9:0];
        mem_wr.data = pwdata[7:0];
    end

    // status word
    always_comb begin
        prdata = '0;
        if (status_rd) begin
            prdata[0]   = busy;
            prdata[1]   = valid;
            prdata[7:4] = answer;
        end
    end

    // start pulse, one cycle after the accepted access
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start <= 1'b0;
        end else begin
            start <= access && start_req && !err;
        end
    end

    // apb protocol: access phase only inside a selected transfer
    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset) penable |-> psel
    ) else $error("penable high without psel");

endmodule

//--- src/layer_mem.sv
module layer_mem #(
    parameter int DEPTH = 549
) (
    input  logic               clk,
    input  cnn_pkg::mem_wr_t   mem_wr,
    input  cnn_pkg::mem_addr_t rd_addr_a,
    input  cnn_pkg::mem_addr_t rd_addr_b,
    output cnn_pkg::byte_t     rd_data_a,
    output cnn_pkg::byte_t     rd_data_b
);
    import cnn_pkg::*;

    // byte array holding features, weights and biases
    byte_t mem [DEPTH];

    // host write port
    always_ff @(posedge clk) begin
        if (mem_wr.en) begin
            mem[mem_wr.addr] <= mem_wr.data;
        end
    end

    // port a, feature side
    always_ff @(posedge clk) begin
        rd_data_a <= mem[rd_addr_a];  // one cycle latency
    end

    // port b, weight or bias side
    always_ff @(posedge clk) begin
        rd_data_b <= mem[rd_addr_b];
    end

    // front end range check must keep writes inside the array
    a_wr_in_range: assert property (
        @(posedge clk) mem_wr.en |-> (int'(mem_wr.addr) < DEPTH)
    ) else $error("layer memory write out of range");

endmodule

//--- src/dense_classifier.sv
module dense_classifier #(
    parameter int N_IN    = 49,
    parameter int N_CLASS = 10
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    output cnn_pkg::mem_addr_t rd_addr_a,
    output cnn_pkg::mem_addr_t rd_addr_b,
    input  cnn_pkg::byte_t     rd_data_a,
    input  cnn_pkg::byte_t     rd_data_b,
    output logic               busy,
    output logic               valid,
    output cnn_pkg::class_t    answer
);
    import cnn_pkg::*;

    // address bases from the memory layout
    localparam mem_addr_t W_BASE     = mem_addr_t'(N_IN);
    localparam mem_addr_t B_BASE     = mem_addr_t'(N_IN * (1 + N_CLASS));
    localparam mem_addr_t LAST_IN    = mem_addr_t'(N_IN - 1);
    localparam class_t    LAST_CLASS = class_t'(N_CLASS - 1);

    cls_state_t  state;
    mem_addr_t   in_idx;     // feature index of the address going out
    mem_addr_t   w_addr;     // running weight address
    class_t      cls_idx;
    class_t      best_idx;
    acc_t        acc;
    acc_t        max_score;
    acc_t        score;
    logic        prod_vld;   // read data belongs to a MAC address
    logic [15:0] prod;
    logic        take;

    // read addresses, bias goes out on port b during BIAS
    assign rd_addr_a = in_idx;
    assign rd_addr_b = (state == BIAS) ? B_BASE + mem_addr_t'(cls_idx) : w_addr;

    assign prod  = rd_data_a * rd_data_b;
    assign score = acc + acc_t'(rd_data_b);  // bias data arrives in COMPARE

    // class 0 seeds the max, later classes need a strictly higher score
    assign take = (cls_idx == '0) || (score > max_score);

    assign busy  = (state == MAC) || (state == BIAS) || (state == COMPARE);
    assign valid = (state == DONE);

    // control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            in_idx   <= '0;
            w_addr   <= W_BASE;
            cls_idx  <= '0;
            prod_vld <= 1'b0;
            answer   <= '0;
        end else begin
            prod_vld <= (state == MAC);
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state   <= MAC;
                        in_idx  <= '0;
                        w_addr  <= W_BASE;
                        cls_idx <= '0;
                    end
                end
                MAC: begin
                    in_idx <= in_idx + 1'b1;
                    w_addr <= w_addr + 1'b1;  // walks straight into the next class row
                    if (in_idx == LAST_IN) begin
                        state <= BIAS;
                    end
                end
                BIAS: begin
                    state <= COMPARE;
                end
                COMPARE: begin
                    in_idx <= '0;
                    if (cls_idx == LAST_CLASS) begin
                        state  <= DONE;
                        answer <= take ? cls_idx : best_idx;
                    end else begin
                        cls_idx <= cls_idx + 1'b1;
                        state   <= MAC;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (prod_vld) begin
            acc <= acc + acc_t'(prod);  // last product lands in BIAS
        end
        if (state == COMPARE) begin
            acc <= '0;
            if (take) begin
                max_score <= score;
                best_idx  <= cls_idx;
            end
        end else if ((state == IDLE || state == DONE) && start) begin
            acc <= '0;
        end
    end

    // result must name a real class
    a_answer_range: assert property (
        @(posedge clk) disable iff (reset) valid |-> (int'(answer) < N_CLASS)
    ) else $error("answer out of class range");

    a_valid_not_busy: assert property (
        @(posedge clk) disable iff (reset) !(valid && busy)
    ) else $error("valid and busy together");

endmodule

//--- src/digit_classifier_top.sv
module digit_classifier_top #(
    parameter int N_IN    = cnn_pkg::DEF_N_IN,
    parameter int N_CLASS = cnn_pkg::DEF_N_CLASS
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  cnn_pkg::apb_addr_t paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    output cnn_pkg::class_t    answer,
    output logic               number_valid
);
    import cnn_pkg::*;

    // features + weights + biases
    localparam int DEPTH = N_IN * (1 + N_CLASS) + N_CLASS;

    mem_wr_t   mem_wr;
    logic      start;
    logic      busy;
    mem_addr_t rd_addr_a;
    mem_addr_t rd_addr_b;
    byte_t     rd_data_a;
    byte_t     rd_data_b;

    apb_frontend #(
        .N_IN    (N_IN),
        .N_CLASS (N_CLASS)
    ) u_apb_frontend (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .busy    (busy),
        .valid   (number_valid),
        .answer  (answer),
        .mem_wr  (mem_wr),
        .start   (start)
    );

    layer_mem #(
        .DEPTH (DEPTH)
    ) u_layer_mem (
        .clk       (clk),
        .mem_wr    (mem_wr),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    dense_classifier #(
        .N_IN    (N_IN),
        .N_CLASS (N_CLASS)
    ) u_dense_classifier (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .busy      (busy),
        .valid     (number_valid),
        .answer    (answer)
    );

endmodule

//--- dv/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// 32 bit galois lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] s;
    s = state >> 1;
    if (state[0]) begin
        s = s ^ 32'h8020_0003;
    end
    return s;
endfunction

// one lfsr step for every bit taken, lsb first
function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int k = 0; k < n; k++) begin
        value[k] = lfsr[0];
        lfsr     = lfsr_next(lfsr);
    end
    return value;
endfunction

function automatic byte_t random_byte();
    return byte_t'(random_bits(8));
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
        stop_with_failure();
    end
endtask

// starts and ends on a falling edge, bus left idle
task automatic apb_transfer(input logic write, input apb_addr_t addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    waited  = 0;
    psel    = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready) begin
        if (waited == TIMEOUT) begin
            $display("ERROR: pready stayed low for %0d cycles", TIMEOUT);
            stop_with_failure();
        end
        @(negedge clk);
        #1;
        waited++;
    end
    rdata = prdata;  // sampled mid access cycle
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, output logic err);
    logic [31:0] ignored;
    apb_transfer(1'b1, addr, data, ignored, err);
endtask

task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
    apb_transfer(1'b0, addr, 32'h0, data, err);
endtask

`endif

//--- dv/tb_digit_classifier.sv
module tb_digit_classifier;
    timeunit 1ns;
    timeprecision 100ps;
    import cnn_pkg::*;

    localparam int N_IN    = DEF_N_IN;
    localparam int N_CLASS = DEF_N_CLASS;
    localparam int DEPTH   = N_IN * (1 + N_CLASS) + N_CLASS;
    localparam int W_BASE  = N_IN;
    localparam int B_BASE  = N_IN * (1 + N_CLASS);
    localparam int LATENCY = N_CLASS * (N_IN + 2) + 2;
    localparam int TIMEOUT = 2000;
    localparam int N_SETS  = 8;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    class_t      answer;
    logic        number_valid;

    logic [31:0] lfsr;
    byte_t       model_mem [DEPTH];  // shadow of the layer memory

    digit_classifier_top #(
        .N_IN    (N_IN),
        .N_CLASS (N_CLASS)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .answer       (answer),
        .number_valid (number_valid)
    );

    `include "tb_util.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // strictly greater wins so ties keep the lower class
    function automatic class_t model_answer();
        int     score;
        int     best_score;
        class_t best;
        best_score = -1;
        best       = '0;
        for (int c = 0; c < N_CLASS; c++) begin
            score = int'(model_mem[B_BASE + c]);
            for (int i = 0; i < N_IN; i++) begin
                score += int'(model_mem[i]) * int'(model_mem[W_BASE + c * N_IN + i]);
            end
            if (score > best_score) begin
                best_score = score;
                best       = class_t'(c);
            end
        end
        return best;
    endfunction

    task automatic load_byte(input int index, input byte_t value);
        logic err;
        apb_write(apb_addr_t'(index), {24'h0, value}, err);
        check_value("memory load pslverr", 0, 32'(err));
        model_mem[index] = value;
    endtask

    task automatic start_run();
        logic err;
        apb_write(CTRL_ADDR, 32'h1, err);
        check_value("start pslverr", 0, 32'(err));
    endtask

    // the start access cycle counts as cycle 1
    task automatic wait_valid(output int cycles, output logic valid_after_start);
        logic seen_low;
        seen_low          = 1'b0;
        cycles            = 1;
        valid_after_start = 1'bx;
        while (!(seen_low && number_valid)) begin
            if (!number_valid) begin
                seen_low = 1'b1;  // old result must drop first
            end
            if (cycles == TIMEOUT) begin
                $display("ERROR: the result never became valid within %0d cycles", TIMEOUT);
                stop_with_failure();
            end
            @(negedge clk);
            cycles++;
            if (cycles == 2) begin
                valid_after_start = number_valid;
            end
        end
    endtask

    task automatic check_result(input string name, input class_t expected);
        logic [31:0] status;
        logic        err;
        check_value({name, " answer port"}, 32'(expected), 32'(answer));
        apb_read(STATUS_ADDR, status, err);
        check_value({name, " status pslverr"}, 0, 32'(err));
        check_value({name, " status busy"}, 0, 32'(status[0]));
        check_value({name, " status valid"}, 1, 32'(status[1]));
        check_value({name, " status answer"}, 32'(expected), 32'(status[7:4]));
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        int          cycles;
        logic        cleared;
        int          tie_lo;
        int          tie_hi;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        reset   = 1'b1;
        lfsr    = 32'd73090;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        check_value("reset number_valid", 0, 32'(number_valid));
        check_value("reset pslverr", 0, 32'(pslverr));
        apb_read(STATUS_ADDR, rd, err);
        check_value("reset status", 0, rd);
        check_value("reset status pslverr", 0, 32'(err));

        // random data sets with a latency check on each run
        for (int run = 0; run < N_SETS; run++) begin
            for (int a = 0; a < DEPTH; a++) begin
                load_byte(a, random_byte());
            end
            start_run();
            wait_valid(cycles, cleared);
            check_value($sformatf("random set %0d latency", run), LATENCY, cycles);
            check_result($sformatf("random set %0d", run), model_answer());
        end

        // zero weights and two equal top biases
        tie_lo = 1 + int'(random_bits(4)) % (N_CLASS - 2);
        tie_hi = tie_lo + 1 + int'(random_bits(4)) % (N_CLASS - 1 - tie_lo);
        for (int i = 0; i < N_CLASS * N_IN; i++) begin
            load_byte(W_BASE + i, 8'h00);
        end
        for (int c = 0; c < N_CLASS; c++) begin
            load_byte(B_BASE + c, byte_t'(random_bits(7)));
        end
        load_byte(B_BASE + tie_lo, 8'hff);
        load_byte(B_BASE + tie_hi, 8'hff);
        start_run();
        wait_valid(cycles, cleared);
        check_value("tie latency", LATENCY, cycles);
        check_result("tie", class_t'(tie_lo));

        // rejected transfers
        apb_write(apb_addr_t'(DEPTH), 32'h5a, err);
        check_value("write at depth pslverr", 1, 32'(err));
        apb_read(12'h408, rd, err);
        check_value("unmapped read pslverr", 1, 32'(err));
        apb_read(12'h010, rd, err);
        check_value("memory read pslverr", 1, 32'(err));
        start_run();
        apb_read(STATUS_ADDR, rd, err);  // run in flight
        check_value("status while busy pslverr", 0, 32'(err));
        check_value("status while busy busy", 1, 32'(rd[0]));
        check_value("status while busy valid", 0, 32'(rd[1]));
        apb_write(apb_addr_t'(B_BASE), 32'hff, err);  // would make class 0 win
        check_value("write while busy pslverr", 1, 32'(err));
        apb_write(CTRL_ADDR, 32'h1, err);
        check_value("start while busy pslverr", 1, 32'(err));
        wait_valid(cycles, cleared);
        check_result("after rejected writes", model_answer());

        // restart with new biases while the old result is held
        for (int c = 0; c < N_CLASS; c++) begin
            load_byte(B_BASE + c, random_byte());
        end
        check_value("valid held before restart", 1, 32'(number_valid));
        start_run();
        wait_valid(cycles, cleared);
        check_value("restart clears valid", 0, 32'(cleared));
        check_value("restart latency", LATENCY, cycles);
        check_result("restart", model_answer());

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+dv
src/cnn_pkg.sv
src/apb_frontend.sv
src/layer_mem.sv
src/dense_classifier.sv
src/digit_classifier_top.sv
dv/tb_digit_classifier.sv

//--- run_sim.sh
#!/bin/sh
# build and run the classifier testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_digit_classifier -f verilog.f \
    -o tb_digit_classifier || { echo "build failed"; exit 1; }

./obj_dir/tb_digit_classifier > sim.log 2>&1
cat sim.log

grep -q "^PASS: all tests$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
